//--- Bender.yml
package:
  name: ifu

sources:
  - hdl/ifu_pkg.sv
  - hdl/ifu_l1i.sv
  - hdl/ifu_fetch_ctrl.sv
  - hdl/ifu_top.sv
  - target: test
    files:
      - tests/tb_ifu.sv

//--- all.f
hdl/ifu_pkg.sv
hdl/ifu_l1i.sv
hdl/ifu_fetch_ctrl.sv
hdl/ifu_top.sv
tests/tb_ifu.sv

//--- hdl/ifu_fetch_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module ifu_fetch_ctrl (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        next_ready_i,
  input  wire                        redirect_i,
  input  wire [ifu_pkg::XLEN-1:0]    npc_i,
  input  wire                        retire_i,
  input  wire [ifu_pkg::XLEN-1:0]    retire_pc_i,
  input  wire                        hit_i,
  input  wire [ifu_pkg::XLEN-1:0]    inst_i,
  input  wire                        l1i_idle_i,
  output logic [ifu_pkg::XLEN-1:0]   fetch_pc_o,
  output logic                       flush_o,
  output logic                       valid_o,
  output logic [ifu_pkg::XLEN-1:0]   pc_o,
  output logic [ifu_pkg::XLEN-1:0]   inst_o,
  output logic                       spec_o,
  output logic                       good_spec_o,
  output logic                       bad_spec_o
);

  logic [ifu_pkg::XLEN-1:0] pc_q;
  logic                     hazard_q;

  logic [ifu_pkg::XLEN-1:0] btb_q;
  logic                     btb_valid_q;

  logic                     spec_q;
  logic [ifu_pkg::XLEN-1:0] spec_target_q;
  logic [ifu_pkg::XLEN-1:0] spec_fall_q;
  logic                     spec_cond_q;
  logic                     good_q;
  logic                     bad_q;
  logic [ifu_pkg::XLEN-1:0] recover_pc_q;

  logic [6:0] opcode;
  logic       is_cond;
  logic       is_ctrl;
  logic       is_load;
  logic       is_store;
  logic       is_fence;
  logic       redirect_hit;
  logic       retire_hit;
  logic       bad_now;
  logic       good_now;
  logic       handoff;
  logic       hazard_clear;
  logic       recover;

  assign opcode   = inst_i[6:0];
  assign is_cond  = (opcode == ifu_pkg::OP_BRANCH);
  assign is_ctrl  = is_cond || (opcode == ifu_pkg::OP_JAL) ||
                    (opcode == ifu_pkg::OP_JALR) || (opcode == ifu_pkg::OP_SYSTEM);
  assign is_load  = (opcode == ifu_pkg::OP_LOAD);
  assign is_store = (opcode == ifu_pkg::OP_STORE);
  assign is_fence = (inst_i == ifu_pkg::INST_FENCE_I);

  // Check the back end against the predicted target.
  assign redirect_hit = redirect_i && (npc_i == spec_target_q);
  assign retire_hit   = retire_i && ((retire_pc_i + 32'd4) == spec_target_q);
  assign bad_now  = spec_q && ((redirect_i && !redirect_hit) || (retire_i && !retire_hit));
  assign good_now = spec_q && !bad_now && (redirect_hit || retire_hit);

  // Memory ops wait until the speculative path is resolved.
  assign valid_o = hit_i && !hazard_q && !bad_spec_o && !(spec_q && (is_load || is_store));
  assign handoff = valid_o && next_ready_i;

  assign hazard_clear = hazard_q && !spec_q && !bad_q && (redirect_i || retire_i);
  assign recover      = bad_q && next_ready_i && l1i_idle_i;

  assign fetch_pc_o  = pc_q;
  assign pc_o        = pc_q;
  assign inst_o      = inst_i;
  assign flush_o     = handoff && is_fence;
  assign spec_o      = spec_q;
  assign good_spec_o = good_q;
  assign bad_spec_o  = bad_q || bad_now;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q        <= ifu_pkg::PC_INIT;
      hazard_q    <= 1'b0;
      btb_valid_q <= 1'b0;
      spec_q      <= 1'b0;
      good_q      <= 1'b0;
      bad_q       <= 1'b0;
    end else begin
      good_q <= good_now; // One-cycle pulse.
      if (redirect_i) begin
        btb_valid_q <= 1'b1;
      end
      if (good_now) begin
        spec_q <= 1'b0;
      end
      if (bad_now) begin
        spec_q <= 1'b0;
        bad_q  <= 1'b1;
      end
      if (hazard_clear) begin
        hazard_q <= 1'b0;
        pc_q     <= redirect_i ? npc_i : pc_q + 32'd4;
      end
      if (handoff) begin
        if (is_load || is_fence) begin
          hazard_q <= 1'b1;
        end else if (is_ctrl) begin
          if (btb_valid_q && !spec_q) begin
            pc_q   <= btb_q;
            spec_q <= 1'b1;
          end else begin
            hazard_q <= 1'b1; // No usable target so wait for the back end.
          end
        end else begin
          pc_q <= pc_q + 32'd4;
        end
      end
      if (recover) begin
        bad_q    <= 1'b0;
        hazard_q <= 1'b0;
        pc_q     <= recover_pc_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (redirect_i) begin
      btb_q <= npc_i;
    end
    if (handoff && is_ctrl && btb_valid_q && !spec_q) begin
      spec_target_q <= btb_q;
      spec_fall_q   <= pc_q + 32'd4;
      spec_cond_q   <= is_cond;
    end
    // A taken-predicted branch that just retires falls through.
    if (bad_now) begin
      recover_pc_q <= (!redirect_i && spec_cond_q) ? spec_fall_q : npc_i;
    end
  end

  a_spec_exclusive: assert property (
    @(posedge clk) disable iff (rst)
    !(good_spec_o && bad_spec_o)
  );

  a_no_spec_in_bad: assert property (
    @(posedge clk) disable iff (rst)
    bad_q |-> !spec_q
  );

endmodule

`default_nettype wire

//--- hdl/ifu_l1i.sv
`timescale 1ns/1ns
`default_nettype none

module ifu_l1i #(
  parameter int unsigned SETS_LOG2 = 2,
  parameter int unsigned LINE_LOG2 = 1
) (
  input  wire                        clk,
  input  wire                        rst,
  input  wire [ifu_pkg::XLEN-1:0]    fetch_pc_i,
  input  wire                        flush_i,
  output logic [ifu_pkg::XLEN-1:0]   araddr_o,
  output logic                       arvalid_o,
  output logic                       busy_o,
  input  wire [ifu_pkg::XLEN-1:0]    rdata_i,
  input  wire                        rvalid_i,
  output logic                       hit_o,
  output logic [ifu_pkg::XLEN-1:0]   inst_o,
  output logic                       idle_o
);

  localparam int unsigned SETS    = 1 << SETS_LOG2;
  localparam int unsigned WORDS   = 1 << LINE_LOG2;
  localparam int unsigned IDX_LSB = 2 + LINE_LOG2;
  localparam int unsigned TAG_LSB = IDX_LSB + SETS_LOG2;
  localparam int unsigned TAG_W   = ifu_pkg::XLEN - TAG_LSB;
  localparam int unsigned LINE_W  = ifu_pkg::XLEN - IDX_LSB;

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_REQ  = 2'd1; // arvalid held until rvalid.
  localparam logic [1:0] S_STEP = 2'd2; // Request gap between words.
  localparam logic [1:0] S_DONE = 2'd3; // Line complete, set valid bit.

  logic [ifu_pkg::XLEN-1:0] data_q [SETS][WORDS];
  logic [TAG_W-1:0]         tag_q  [SETS][WORDS];
  logic [SETS-1:0]          valid_q;

  logic [1:0]           state_q;
  logic [LINE_W-1:0]    fill_line_q;
  logic [LINE_LOG2-1:0] word_q;

  logic [TAG_W-1:0]     pc_tag;
  logic [SETS_LOG2-1:0] pc_idx;
  logic [LINE_LOG2-1:0] pc_off;
  logic [SETS_LOG2-1:0] fill_idx;
  logic [TAG_W-1:0]     fill_tag;
  logic                 last_word;

  assign pc_tag = fetch_pc_i[ifu_pkg::XLEN-1:TAG_LSB];
  assign pc_idx = fetch_pc_i[TAG_LSB-1:IDX_LSB];
  assign pc_off = fetch_pc_i[IDX_LSB-1:2];

  assign fill_idx  = fill_line_q[SETS_LOG2-1:0];
  assign fill_tag  = fill_line_q[LINE_W-1:SETS_LOG2];
  assign last_word = (word_q == LINE_LOG2'(WORDS - 1));

  // Lookup is only trusted while no fill is running.
  assign idle_o = (state_q == S_IDLE);
  assign hit_o  = idle_o && valid_q[pc_idx] && (tag_q[pc_idx][pc_off] == pc_tag);
  assign inst_o = data_q[pc_idx][pc_off];

  assign araddr_o  = {fill_line_q, word_q, 2'b00};
  assign arvalid_o = (state_q == S_REQ);
  assign busy_o    = !idle_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
      valid_q <= '0;
      word_q  <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (!hit_o) begin
            word_q  <= '0; // Fill always starts at the line base.
            state_q <= S_REQ;
          end
        end
        S_REQ: begin
          if (rvalid_i) begin
            state_q <= last_word ? S_DONE : S_STEP;
          end
        end
        S_STEP: begin
          word_q  <= word_q + 1'b1;
          state_q <= S_REQ;
        end
        S_DONE: begin
          valid_q[fill_idx] <= 1'b1;
          state_q           <= S_IDLE;
        end
        default: state_q <= S_IDLE;
      endcase
      if (flush_i) begin
        valid_q <= '0;
      end
    end
  end

  // Line address is captured when the miss is seen.
  always_ff @(posedge clk) begin
    if (idle_o && !hit_o) begin
      fill_line_q <= fetch_pc_i[ifu_pkg::XLEN-1:IDX_LSB];
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_REQ && rvalid_i) begin
      data_q[fill_idx][word_q] <= rdata_i;
      tag_q[fill_idx][word_q]  <= fill_tag;
    end
  end

  a_no_req_on_hit: assert property (
    @(posedge clk) disable iff (rst)
    (idle_o && hit_o) |=> !arvalid_o
  );

  a_addr_stable: assert property (
    @(posedge clk) disable iff (rst)
    (arvalid_o && !rvalid_i) |=> (arvalid_o && $stable(araddr_o))
  );

endmodule

`default_nettype wire

//--- hdl/ifu_pkg.sv
`default_nettype none

package ifu_pkg;

  // Word and address width.
  localparam int unsigned XLEN = 32;

  // First fetch address after reset.
  localparam logic [XLEN-1:0] PC_INIT = 32'h8000_0000;

  // Major opcodes, bits [6:0] of the instruction.
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;

  // fence.i with rd, rs1 and imm all zero.
  localparam logic [XLEN-1:0] INST_FENCE_I = 32'h0000_100f;

endpackage

`default_nettype wire

//--- hdl/ifu_top.sv
`timescale 1ns/1ns
`default_nettype none

module ifu_top #(
  parameter int unsigned SETS_LOG2 = 2,
  parameter int unsigned LINE_LOG2 = 1
) (
  input  wire                        clk,
  input  wire                        rst,
  output logic [ifu_pkg::XLEN-1:0]   araddr_o,
  output logic                       arvalid_o,
  output logic                       busy_o,
  input  wire [ifu_pkg::XLEN-1:0]    rdata_i,
  input  wire                        rvalid_i,
  input  wire                        next_ready_i,
  input  wire                        redirect_i,
  input  wire [ifu_pkg::XLEN-1:0]    npc_i,
  input  wire                        retire_i,
  input  wire [ifu_pkg::XLEN-1:0]    retire_pc_i,
  output logic                       valid_o,
  output logic [ifu_pkg::XLEN-1:0]   pc_o,
  output logic [ifu_pkg::XLEN-1:0]   inst_o,
  output logic                       spec_o,
  output logic                       good_spec_o,
  output logic                       bad_spec_o
);

  logic [ifu_pkg::XLEN-1:0] fetch_pc;
  logic                     flush;
  logic                     hit;
  logic [ifu_pkg::XLEN-1:0] l1i_inst;
  logic                     l1i_idle;

  ifu_fetch_ctrl u_fetch_ctrl (
    .clk          (clk),
    .rst          (rst),
    .next_ready_i (next_ready_i),
    .redirect_i   (redirect_i),
    .npc_i        (npc_i),
    .retire_i     (retire_i),
    .retire_pc_i  (retire_pc_i),
    .hit_i        (hit),
    .inst_i       (l1i_inst),
    .l1i_idle_i   (l1i_idle),
    .fetch_pc_o   (fetch_pc),
    .flush_o      (flush),
    .valid_o      (valid_o),
    .pc_o         (pc_o),
    .inst_o       (inst_o),
    .spec_o       (spec_o),
    .good_spec_o  (good_spec_o),
    .bad_spec_o   (bad_spec_o)
  );

  ifu_l1i #(
    .SETS_LOG2 (SETS_LOG2),
    .LINE_LOG2 (LINE_LOG2)
  ) u_l1i (
    .clk        (clk),
    .rst        (rst),
    .fetch_pc_i (fetch_pc),
    .flush_i    (flush),
    .araddr_o   (araddr_o),
    .arvalid_o  (arvalid_o),
    .busy_o     (busy_o),
    .rdata_i    (rdata_i),
    .rvalid_i   (rvalid_i),
    .hit_o      (hit),
    .inst_o     (l1i_inst),
    .idle_o     (l1i_idle)
  );

endmodule

`default_nettype wire

//--- tests/ifu_golden.txt
// Part 1 at @000: program words from 0x80000000, four per line.
// Part 2 at @040: pc, instruction, flags, argument; a row with pc 0 ends the list.
// Flags nibbles from bit 15: bus (1 no request, 2 line fill), outcome (1 good, 2 bad),
// spec_o at handoff, action (0 none, 1 retire, 2 redirect to argument, 3 hold argument cycles).
@000
00100093 00200093 00002103 00300093
0100006f 00000013 00000013 00000013
00828293 00028067 00008463 00400093
0000100f 00500093 00600093 00700093
@040
// addi, addi, lw stalls until retire, then a held addi.
80000000 00100093 00002000 00000000
80000004 00200093 00001000 00000000
80000008 00002103 00002001 00000000
8000000c 00300093 00001003 00000003
// jal with an empty target buffer waits for the redirect.
80000010 0100006f 00002002 80000020
80000020 00828293 00002000 00000000
// jalr predicted to 0x20 and confirmed.
80000024 00028067 00001102 80000020
80000020 00828293 00001010 00000000
// jalr predicted to 0x20 but redirected to 0x28.
80000024 00028067 00001202 80000028
// beq predicted taken, retired as not taken, recovers to pc + 4.
80000028 00008463 00002201 00000000
8000002c 00400093 00001000 00000000
// fence.i flushes, so the cached line is fetched again.
80000030 0000100f 00002001 00000000
80000034 00500093 00002000 00000000
80000038 00600093 00002000 00000000
8000003c 00700093 00001000 00000000
@0000

//--- tests/tb_ifu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ifu;

  localparam int TIMEOUT    = 200;
  localparam int ROW_BASE   = 64; // Handoff rows start here in the golden image.
  localparam int LINE_BYTES = 8;

  logic        clk;
  logic        rst;
  logic [31:0] araddr_o;
  logic        arvalid_o;
  logic        busy_o;
  logic [31:0] rdata_i;
  logic        rvalid_i;
  logic        next_ready_i;
  logic        redirect_i;
  logic [31:0] npc_i;
  logic        retire_i;
  logic [31:0] retire_pc_i;
  logic        valid_o;
  logic [31:0] pc_o;
  logic [31:0] inst_o;
  logic        spec_o;
  logic        good_spec_o;
  logic        bad_spec_o;

  logic [31:0] gold [256];
  integer      seed;
  int          errors;
  int          req_count;
  int          delay_cnt;
  logic [31:0] last_req;
  logic        timed_out;
  logic        ready_drv;
  logic [31:0] act_flags; // Back-end action for the next falling edge.
  logic [31:0] act_arg;
  logic [31:0] act_pc;
  logic        good_due;
  logic        good_exp;

  ifu_top #(.SETS_LOG2(2), .LINE_LOG2(1)) DUT (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - ifu_pkg::PC_INIT) >> 2;
    if (idx < ROW_BASE) begin
      return gold[idx];
    end else begin
      return ~addr;
    end
  endfunction

  // Loads and fence.i keep fetch stopped until the back end answers.
  function automatic logic holds_fetch(input logic [31:0] inst);
    return (inst[6:0] == ifu_pkg::OP_LOAD) || (inst == ifu_pkg::INST_FENCE_I);
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s expected %h observed %h", $time, name, exp, got);
      errors++;
    end
  endtask

  // Bus memory answers each request after 1 to 4 cycles.
  always @(negedge clk) begin
    if (rst) begin
      rvalid_i  = 1'b0;
      delay_cnt = 0;
    end else if (rvalid_i) begin
      rvalid_i = 1'b0;
    end else if (arvalid_o) begin
      if (delay_cnt == 0) begin
        delay_cnt = 1 + ($unsigned($random(seed)) % 4);
      end
      delay_cnt = delay_cnt - 1;
      if (delay_cnt == 0) begin
        if (araddr_o % LINE_BYTES != 0) begin
          check_val("araddr_o", last_req + 32'd4, araddr_o); // Words go up within a line.
        end
        rdata_i  = mem_word(araddr_o);
        rvalid_i = 1'b1;
        last_req = araddr_o;
        req_count++;
      end
    end
  end

  // One clock. Inputs change on the falling edge, outputs are read 1 ns later.
  task automatic step();
    @(negedge clk);
    next_ready_i = ready_drv;
    redirect_i   = (act_flags[3:0] == 4'd2);
    retire_i     = (act_flags[3:0] == 4'd1);
    npc_i        = act_arg;
    retire_pc_i  = act_pc;
    #1;
    if (good_due) begin
      check_val("good_spec_o", good_exp, good_spec_o); // Pulse comes one cycle later.
    end
    good_due = 1'b0;
    if (redirect_i || retire_i) begin
      check_val("bad_spec_o", act_flags[11:8] == 4'd2, bad_spec_o);
      good_due = 1'b1;
      good_exp = (act_flags[11:8] == 4'd1);
    end
    act_flags = '0;
  endtask

  task automatic wait_handoff(input int row);
    int n;
    n = 0;
    step();
    while (!(valid_o && next_ready_i) && n < TIMEOUT) begin
      step();
      n++;
    end
    if (!(valid_o && next_ready_i)) begin
      $display("Timeout: no handoff to decode for row %0d", row);
      timed_out = 1'b1;
    end
  endtask

  // Decode holds ready low while an instruction waits.
  task automatic hold_ready(input int row, input int cycles);
    int n;
    logic [31:0] held_pc;
    logic [31:0] held_inst;
    n = 0;
    ready_drv = 1'b0;
    step();
    while (!valid_o && n < TIMEOUT) begin
      step();
      n++;
    end
    if (!valid_o) begin
      $display("Timeout: no valid instruction under back-pressure in row %0d", row);
      timed_out = 1'b1;
    end else begin
      held_pc   = pc_o;
      held_inst = inst_o;
      for (n = 0; n < cycles; n++) begin
        step();
        check_val("pc_o", held_pc, pc_o);
        check_val("inst_o", held_inst, inst_o);
        check_val("arvalid_o", 0, arvalid_o);
      end
    end
    ready_drv = 1'b1;
  endtask

  initial begin
    int i;
    int r;
    int base;
    int err0;
    int tests;
    seed = 32'heb1b;
    errors = 0;
    req_count = 0;
    last_req = '0;
    timed_out = 1'b0;
    ready_drv = 1'b1;
    act_flags = '0;
    act_arg = '0;
    act_pc = '0;
    good_due = 1'b0;
    good_exp = 1'b0;
    rst = 1'b1;
    rdata_i = '0;
    rvalid_i = 1'b0;
    next_ready_i = 1'b1;
    redirect_i = 1'b0;
    npc_i = '0;
    retire_i = 1'b0;
    retire_pc_i = '0;
    for (i = 0; i < 256; i++) begin
      gold[i] = (i < ROW_BASE) ? ~(ifu_pkg::PC_INIT + 4 * i) : '0;
    end
    $readmemh("tests/ifu_golden.txt", gold);
    repeat (5) @(negedge clk);
    check_val("pc_o", ifu_pkg::PC_INIT, pc_o);
    check_val("{valid_o,arvalid_o,busy_o,spec_o,good_spec_o,bad_spec_o}", 0,
              {valid_o, arvalid_o, busy_o, spec_o, good_spec_o, bad_spec_o});
    $display("test reset: %s", (errors == 0) ? "ok" : "failed");
    tests = 1;
    rst = 1'b0;
    r = 0;
    base = ROW_BASE;
    while (!timed_out && base + 3 < 256 && gold[base] != 0) begin
      err0 = errors;
      if (gold[base+2][3:0] == 4'd3) begin
        hold_ready(r, gold[base+3]);
      end
      if (!timed_out) begin
        wait_handoff(r);
      end
      if (!timed_out) begin
        check_val("pc_o", gold[base], pc_o);
        check_val("inst_o", gold[base+1], inst_o);
        check_val("spec_o", gold[base+2][7:4], spec_o);
        if (gold[base+2][15:12] == 4'd1 && req_count != 0) begin
          $display("Bus request seen before the cached fetch of row %0d", r);
          errors++;
        end
        if (gold[base+2][15:12] == 4'd2 && req_count == 0) begin
          $display("No line fill seen before the fetch of row %0d", r);
          errors++;
        end
        req_count = 0;
        // Nothing may reach decode before the back end answers.
        if (holds_fetch(gold[base+1]) && gold[base+2][3:0] != 4'd0) begin
          for (i = 0; i < 3; i++) begin
            step();
            check_val("valid_o", 0, valid_o);
          end
        end
        if (gold[base+2][3:0] == 4'd1 || gold[base+2][3:0] == 4'd2) begin
          act_flags = gold[base+2];
          act_arg   = gold[base+3];
          act_pc    = gold[base];
        end
      end
      $display("test row %0d pc %h: %s", r, gold[base], (errors == err0) ? "ok" : "failed");
      tests++;
      r++;
      base += 4;
    end
    step();
    step();
    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
